// ==== Bender.yml ====
package:
  name: snd_out

sources:
  # Design, in compile order
  - files:
      - logic/snd_pkg.sv
      - logic/snd_ctrl.sv
      - logic/snd_pcm_cond.sv
      - logic/snd_sd_dac.sv
      - logic/snd_out_top.sv

  # Testbench
  - target: simulation
    files:
      - dv/snd_clk_gen.sv
      - dv/snd_out_tb.sv

// ==== dv/snd_clk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// 10-unit clock period, reset held for 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module snd_clk_gen (
    output logic clk_dac_o,
    output logic rst_o
);
    initial begin
        clk_dac_o = 1'b0;
        forever #5 clk_dac_o = ~clk_dac_o;
    end

    // Release a little after the edge
    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_dac_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/snd_out_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the audio output block
// Register test, table of audio rows, Wishbone tasks
// Pulse counting over full modulator periods, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module snd_out_tb;
    import snd_pkg::*;

    localparam int DAC_W    = 8;
    localparam int PERIOD   = 1 << DAC_W;
    localparam int ACK_WAIT = 16;

    typedef struct {
        logic [31:0] ctrl;
        logic [31:0] div;
        logic [15:0] left;
        logic [15:0] right;
        int          exp_l;
        int          exp_r;
        string       name;
    } row_t;

    logic        clk_dac;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [15:0] snd_left;
    logic [15:0] snd_right;
    logic        pdm_left;
    logic        pdm_right;

    row_t        rows[$];
    logic [31:0] lfsr_q = 32'h3844;
    int          err_cnt = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    logic        table_ready = 1'b0;

    snd_clk_gen u_clk_gen (
        .clk_dac_o ( clk_dac ),
        .rst_o     ( rst     )
    );

    snd_out_top #(.DAC_W(DAC_W)) u_dut (
        .clk_dac         ( clk_dac   ),
        .rst             ( rst       ),
        .wb_cyc_i        ( wb_cyc    ),
        .wb_stb_i        ( wb_stb    ),
        .wb_we_i         ( wb_we     ),
        .wb_adr_i        ( wb_adr    ),
        .wb_dat_i        ( wb_dat_w  ),
        .wb_dat_o        ( wb_dat_r  ),
        .wb_ack_o        ( wb_ack    ),
        .snd_left_i      ( snd_left  ),
        .snd_right_i     ( snd_right ),
        .snd_pdm_left_o  ( pdm_left  ),
        .snd_pdm_right_o ( pdm_right )
    );

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %08h expected %08h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_state(input snd_wb_state_e got, input snd_wb_state_e exp,
                               input string what);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %s expected %s", $time, what,
                     got.name(), exp.name());
            err_cnt++;
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[14:0], lfsr_q[0]};
        end
    endtask

    // Pulses per period from the control bits, offset binary top byte
    function automatic int model_count(input logic [31:0] ctrl, input logic [15:0] own,
                                       input logic [15:0] left, input bit is_right);
        logic [15:0] s;
        if (ctrl[SND_CTRL_MUTE]) begin
            return PERIOD / 2;
        end
        s = (is_right && !ctrl[SND_CTRL_STEREO]) ? left : own;
        if (ctrl[SND_CTRL_SIGNED]) begin
            s[15] = ~s[15];
        end
        return int'(s[15 -: DAC_W]);
    endfunction

    function automatic row_t make_row(input logic [31:0] ctrl, input logic [31:0] div,
                                      input logic [15:0] left, input logic [15:0] right,
                                      input int exp_l, input int exp_r, input string name);
        row_t r;
        r.ctrl  = ctrl;
        r.div   = div;
        r.left  = left;
        r.right = right;
        r.exp_l = exp_l;
        r.exp_r = exp_r;
        r.name  = name;
        return r;
    endfunction

    // Request held one cycle past ack, ack must already be low then
    task automatic bus_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int            waited;
        snd_wb_state_e phase;
        waited = 0;
        rdata  = '0;
        @(posedge clk_dac);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge clk_dac);
        #1;
        while (!wb_ack && waited < ACK_WAIT) begin
            @(posedge clk_dac);
            #1;
            waited++;
        end
        if (!wb_ack) begin
            $display("error at %0t: no bus ack within %0d cycles for address %0h",
                     $time, ACK_WAIT, adr);
            err_cnt++;
        end else begin
            rdata = wb_dat_r;
            @(posedge clk_dac);
            #1;
            phase = wb_ack ? ACK : IDLE;
            check_state(phase, IDLE, "bus phase one cycle after ack");
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_xfer(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic [3:0] adr, output logic [31:0] data);
        bus_xfer(1'b0, adr, '0, data);
    endtask

    // High cycles and level changes of both outputs over one window
    task automatic measure_window(input int div, output int high_l, output int high_r,
                                  output int flips_l, output int flips_r);
        logic prev_l;
        logic prev_r;
        high_l  = 0;
        high_r  = 0;
        flips_l = 0;
        flips_r = 0;
        prev_l  = pdm_left;
        prev_r  = pdm_right;
        repeat (PERIOD * div) begin
            @(posedge clk_dac);
            #1;
            high_l  += pdm_left;
            high_r  += pdm_right;
            flips_l += (pdm_left != prev_l);
            flips_r += (pdm_right != prev_r);
            prev_l  = pdm_left;
            prev_r  = pdm_right;
        end
    endtask

    task automatic fill_table();
        logic [15:0] l;
        logic [15:0] r;
        rows.push_back(make_row(32'h5, 32'd4, 16'h4000, 16'hC000, 64, 192, "unsigned stereo"));
        rows.push_back(make_row(32'h7, 32'd4, 16'h0000, 16'h8000, 128, 0, "signed stereo"));
        rows.push_back(make_row(32'h1, 32'd4, 16'h2A00, 16'hF000, 42, 42, "mono"));
        rows.push_back(make_row(32'hD, 32'd4, 16'h1234, 16'hFFFF, 128, 128, "mute"));
        rows.push_back(make_row(32'h4, 32'd4, 16'h4000, 16'hC000, -1, -1, "disabled"));
        rows.push_back(make_row(32'h5, 32'd7, 16'h4000, 16'hC000, 64, 192, "divide by 7"));
        draw_bits(16, l);
        draw_bits(16, r);
        rows.push_back(make_row(32'h5, 32'd3, l, r, model_count(32'h5, l, l, 0),
                                model_count(32'h5, r, l, 1), "random unsigned"));
        draw_bits(16, l);
        draw_bits(16, r);
        rows.push_back(make_row(32'h3, 32'd5, l, r, model_count(32'h3, l, l, 0),
                                model_count(32'h3, r, l, 1), "random signed mono"));
    endtask

    task automatic finish_test(input int errs_before, input string name);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_bad++;
        end
        $display("test %0d %s: %s", tests_run, name, (err_cnt == errs_before) ? "ok" : "failed");
    endtask

    task automatic register_test();
        logic [31:0] rd;
        int          errs_before;
        errs_before = err_cnt;
        read_reg(SND_ADDR_CTRL, rd);
        check_data(rd, SND_CTRL_RST, "control after reset");
        read_reg(SND_ADDR_DIV, rd);
        check_data(rd, SND_DIV_RST, "divider after reset");
        write_reg(SND_ADDR_DIV, 32'd9);
        read_reg(SND_ADDR_DIV, rd);
        check_data(rd, 32'd9, "divider readback");
        write_reg(SND_ADDR_CTRL, 32'hD);
        read_reg(SND_ADDR_CTRL, rd);
        check_data(rd, 32'hD, "control readback");
        write_reg(4'h8, 32'hFFFF_FFFF);
        read_reg(4'h8, rd);
        check_data(rd, 32'h0, "undefined address");
        read_reg(SND_ADDR_CTRL, rd);
        check_data(rd, 32'hD, "control after undefined write");
        finish_test(errs_before, "registers");
    endtask

    initial begin
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        snd_left  = '0;
        snd_right = '0;
    end

    initial begin
        logic [31:0] rd;
        int          div;
        int          errs_before;
        int          high_l;
        int          high_r;
        int          flips_l;
        int          flips_r;
        fill_table();
        table_ready = 1'b1;
        @(negedge rst);
        register_test();
        for (int i = 0; i < rows.size(); i++) begin
            errs_before = err_cnt;
            div         = int'(rows[i].div);
            snd_left    = rows[i].left;
            snd_right   = rows[i].right;
            write_reg(SND_ADDR_DIV, rows[i].div);
            write_reg(SND_ADDR_CTRL, rows[i].ctrl);
            read_reg(SND_ADDR_DIV, rd);
            check_data(rd, rows[i].div, "divider readback");
            read_reg(SND_ADDR_CTRL, rd);
            check_data(rd, rows[i].ctrl, "control readback");
            // Settle the conditioner and modulator state
            repeat (PERIOD * div) @(posedge clk_dac);
            #1;
            measure_window(div, high_l, high_r, flips_l, flips_r);
            if (!rows[i].ctrl[SND_CTRL_EN]) begin
                // Frozen outputs are all low or all high
                check_count(high_l % (PERIOD * div), 0, "left high cycles while disabled");
                check_count(high_r % (PERIOD * div), 0, "right high cycles while disabled");
                check_count(flips_l, 0, "left level changes while disabled");
                check_count(flips_r, 0, "right level changes while disabled");
            end else begin
                check_count(high_l / div, rows[i].exp_l, "left pulse count");
                check_count(high_r / div, rows[i].exp_r, "right pulse count");
            end
            finish_test(errs_before, rows[i].name);
        end
        $display("summary: %0d tests, %0d failing, %0d errors", tests_run, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int max_div;
        int limit;
        wait (table_ready);
        max_div = 1;
        foreach (rows[i]) begin
            if (int'(rows[i].div) > max_div) begin
                max_div = int'(rows[i].div);
            end
        end
        limit = rows.size() * (2 * PERIOD * max_div + 100);
        repeat (limit) @(posedge clk_dac);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/snd_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control module of the audio output block
// Wishbone classic register file with one-cycle ack
// Clock-enable generator driven by the divider register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module snd_ctrl (
    input  wire logic        clk_dac,
    input  wire logic        rst,
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [3:0]  wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    output logic      [31:0] wb_dat_o,
    output logic             wb_ack_o,
    output logic             cen_o,
    output logic             pcm_signed_o,
    output logic             stereo_o,
    output logic             mute_o
);
    import snd_pkg::*;

    snd_wb_state_e         state_q;
    logic [SND_CTRL_W-1:0] ctrl_q;
    logic [SND_DIV_W-1:0]  div_q;
    logic [SND_DIV_W-1:0]  div_eff;
    logic [SND_DIV_W-1:0]  cnt_q;
    logic [31:0]           rd_data;
    logic                  bus_req;
    logic                  ctrl_wr;
    logic                  div_wr;

    // New request only seen from IDLE, so a held stb is not acked twice
    assign bus_req = wb_cyc_i && wb_stb_i && (state_q == IDLE);
    assign ctrl_wr = bus_req && wb_we_i && (wb_adr_i == SND_ADDR_CTRL);
    assign div_wr  = bus_req && wb_we_i && (wb_adr_i == SND_ADDR_DIV);

    assign wb_ack_o = (state_q == ACK);

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            SND_ADDR_CTRL: rd_data[SND_CTRL_W-1:0] = ctrl_q;
            SND_ADDR_DIV:  rd_data[SND_DIV_W-1:0]  = div_q;
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            ctrl_q  <= SND_CTRL_RST[SND_CTRL_W-1:0];
            div_q   <= SND_DIV_RST[SND_DIV_W-1:0];
        end else begin
            case (state_q)
                IDLE: begin
                    if (bus_req) begin
                        state_q <= ACK;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
            if (ctrl_wr) begin
                ctrl_q <= wb_dat_i[SND_CTRL_W-1:0];
            end
            if (div_wr) begin
                div_q <= wb_dat_i[SND_DIV_W-1:0];
            end
        end
    end

    // Read data captured together with the ack
    always_ff @(posedge clk_dac) begin
        if (bus_req) begin
            wb_dat_o <= rd_data;
        end
    end

    // A divider of zero behaves as one
    assign div_eff = (div_q == '0) ? SND_DIV_W'(1) : div_q;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (div_wr || cnt_q >= div_eff - 1'b1) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign cen_o        = ctrl_q[SND_CTRL_EN] && (cnt_q == div_eff - 1'b1);
    assign pcm_signed_o = ctrl_q[SND_CTRL_SIGNED];
    assign stereo_o     = ctrl_q[SND_CTRL_STEREO];
    assign mute_o       = ctrl_q[SND_CTRL_MUTE];

    // Ack is a single-cycle pulse even with stb held
    a_ack_single: assert property (@(posedge clk_dac) disable iff (rst)
        wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

// ==== logic/snd_out_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Audio output block top level
// Control module, sample conditioner, left and right DACs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module snd_out_top #(
    parameter int DAC_W = 12
) (
    input  wire logic                          clk_dac,
    input  wire logic                          rst,
    input  wire logic                          wb_cyc_i,
    input  wire logic                          wb_stb_i,
    input  wire logic                          wb_we_i,
    input  wire logic [3:0]                    wb_adr_i,
    input  wire logic [31:0]                   wb_dat_i,
    output logic      [31:0]                   wb_dat_o,
    output logic                               wb_ack_o,
    input  wire logic [snd_pkg::SND_PCM_W-1:0] snd_left_i,
    input  wire logic [snd_pkg::SND_PCM_W-1:0] snd_right_i,
    output logic                               snd_pdm_left_o,
    output logic                               snd_pdm_right_o
);
    logic             cen;
    logic             pcm_signed;
    logic             stereo;
    logic             mute;
    logic [DAC_W-1:0] pcm_left;
    logic [DAC_W-1:0] pcm_right;

    snd_ctrl u_ctrl (
        .clk_dac      ( clk_dac    ),
        .rst          ( rst        ),
        .wb_cyc_i     ( wb_cyc_i   ),
        .wb_stb_i     ( wb_stb_i   ),
        .wb_we_i      ( wb_we_i    ),
        .wb_adr_i     ( wb_adr_i   ),
        .wb_dat_i     ( wb_dat_i   ),
        .wb_dat_o     ( wb_dat_o   ),
        .wb_ack_o     ( wb_ack_o   ),
        .cen_o        ( cen        ),
        .pcm_signed_o ( pcm_signed ),
        .stereo_o     ( stereo     ),
        .mute_o       ( mute       )
    );

    snd_pcm_cond #(.DAC_W(DAC_W)) u_pcm_cond (
        .clk_dac      ( clk_dac     ),
        .rst          ( rst         ),
        .cen_i        ( cen         ),
        .pcm_signed_i ( pcm_signed  ),
        .stereo_i     ( stereo      ),
        .mute_i       ( mute        ),
        .snd_left_i   ( snd_left_i  ),
        .snd_right_i  ( snd_right_i ),
        .pcm_left_o   ( pcm_left    ),
        .pcm_right_o  ( pcm_right   )
    );

    snd_sd_dac #(.DAC_W(DAC_W)) u_dac_left (
        .clk_dac ( clk_dac        ),
        .rst     ( rst            ),
        .cen_i   ( cen            ),
        .pcm_i   ( pcm_left       ),
        .pdm_o   ( snd_pdm_left_o )
    );

    snd_sd_dac #(.DAC_W(DAC_W)) u_dac_right (
        .clk_dac ( clk_dac         ),
        .rst     ( rst             ),
        .cen_i   ( cen             ),
        .pcm_i   ( pcm_right       ),
        .pdm_o   ( snd_pdm_right_o )
    );

endmodule

`default_nettype wire

// ==== logic/snd_pcm_cond.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PCM sample conditioning ahead of the modulators
// Sign conversion, mono folding, mute and truncation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module snd_pcm_cond #(
    parameter int DAC_W = 12
) (
    input  wire logic                         clk_dac,
    input  wire logic                         rst,
    input  wire logic                         cen_i,
    input  wire logic                         pcm_signed_i,
    input  wire logic                         stereo_i,
    input  wire logic                         mute_i,
    input  wire logic [snd_pkg::SND_PCM_W-1:0] snd_left_i,
    input  wire logic [snd_pkg::SND_PCM_W-1:0] snd_right_i,
    output logic      [DAC_W-1:0]             pcm_left_o,
    output logic      [DAC_W-1:0]             pcm_right_o
);
    import snd_pkg::*;

    localparam int PCM_W = SND_PCM_W;

    // Midpoint code, one followed by zeros
    localparam logic [DAC_W-1:0] MID_CODE = {1'b1, {(DAC_W-1){1'b0}}};

    logic [PCM_W-1:0] left_ob;
    logic [PCM_W-1:0] right_ob;
    logic [PCM_W-1:0] right_sel;

    // Two's complement to offset binary by flipping the MSB
    assign left_ob  = {snd_left_i[PCM_W-1] ^ pcm_signed_i, snd_left_i[PCM_W-2:0]};
    assign right_ob = {snd_right_i[PCM_W-1] ^ pcm_signed_i, snd_right_i[PCM_W-2:0]};

    // Mono takes the left sample on both sides
    assign right_sel = stereo_i ? right_ob : left_ob;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            pcm_left_o  <= '0;
            pcm_right_o <= '0;
        end else if (cen_i) begin
            if (mute_i) begin
                pcm_left_o  <= MID_CODE;
                pcm_right_o <= MID_CODE;
            end else begin
                // Keep only the top DAC_W bits
                pcm_left_o  <= left_ob[PCM_W-1 -: DAC_W];
                pcm_right_o <= right_sel[PCM_W-1 -: DAC_W];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/snd_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions of the audio output block
// Register map, control bit positions and reset values
// Wishbone response state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package snd_pkg;

    // Input PCM sample width from the game core
    localparam int SND_PCM_W = 16;

    // Byte addresses on the Wishbone bus
    localparam logic [3:0] SND_ADDR_CTRL = 4'h0;
    localparam logic [3:0] SND_ADDR_DIV  = 4'h4;

    // Control register bits
    localparam int SND_CTRL_EN     = 0;
    localparam int SND_CTRL_SIGNED = 1;
    localparam int SND_CTRL_STEREO = 2;
    localparam int SND_CTRL_MUTE   = 3;

    // Implemented register widths
    localparam int SND_CTRL_W = 4;
    localparam int SND_DIV_W  = 16;

    // Values after reset, enabled stereo and a divide by four
    localparam logic [31:0] SND_CTRL_RST = (32'd1 << SND_CTRL_EN)
                                         | (32'd1 << SND_CTRL_STEREO);
    localparam logic [31:0] SND_DIV_RST  = 32'd4;

    // Bus response state
    typedef enum logic {
        IDLE,
        ACK
    } snd_wb_state_e;

endpackage

`default_nettype wire

// ==== logic/snd_sd_dac.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First-order sigma-delta modulator with 1-bit output
// One instance per audio channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module snd_sd_dac #(
    parameter int DAC_W = 12
) (
    input  wire logic             clk_dac,
    input  wire logic             rst,
    input  wire logic             cen_i,
    input  wire logic [DAC_W-1:0] pcm_i,
    output logic                  pdm_o
);
    logic [DAC_W-1:0] acc_q;
    logic [DAC_W:0]   sum;

    // Error feedback: the residue stays in the accumulator,
    // the carry is the output pulse
    assign sum = {1'b0, acc_q} + {1'b0, pcm_i};

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc_q <= '0;
            pdm_o <= 1'b0;
        end else if (cen_i) begin
            acc_q <= sum[DAC_W-1:0];
            pdm_o <= sum[DAC_W];
        end
    end

    // Output only moves on a clock enable
    a_pdm_hold: assert property (@(posedge clk_dac) disable iff (rst)
        !cen_i |=> $stable(pdm_o));

endmodule

`default_nettype wire

// ==== tb.f ====
logic/snd_pkg.sv
logic/snd_ctrl.sv
logic/snd_pcm_cond.sv
logic/snd_sd_dac.sv
logic/snd_out_top.sv
dv/snd_clk_gen.sv
dv/snd_out_tb.sv
